/* biu_pkg.sv */
// shared bus encodings; select and address helpers assume a data bus of at most 64 bits
package biu_pkg;

  ////////////////////
  // core side encodings
  ////////////////////

  typedef enum logic [2:0] {
    BIU_SINGLE = 3'd0,
    BIU_INCR   = 3'd1,  // open length, runs as a single here
    BIU_WRAP4  = 3'd2,
    BIU_INCR4  = 3'd3,
    BIU_WRAP8  = 3'd4,
    BIU_INCR8  = 3'd5,
    BIU_WRAP16 = 3'd6,
    BIU_INCR16 = 3'd7
  } biu_type_e;

  typedef enum logic [2:0] {
    SIZE_BYTE  = 3'd0,
    SIZE_HWORD = 3'd1,
    SIZE_WORD  = 3'd2,
    SIZE_DWORD = 3'd3   // XLEN 64 only
  } biu_size_e;

  // protection field: bit 0 data/instr, bit 1 privileged, bit 2 cacheable
  localparam int PROT_PRIVILEGED = 1;

  ////////////////////
  // wishbone B3 tags
  ////////////////////

  typedef enum logic [2:0] {
    CTI_CLASSIC = 3'b000,
    CTI_CONST   = 3'b001,
    CTI_INCR    = 3'b010,
    CTI_EOB     = 3'b111
  } wb_cti_e;

  typedef enum logic [1:0] {
    BTE_LINEAR = 2'b00,
    BTE_WRAP4  = 2'b01,
    BTE_WRAP8  = 2'b10,
    BTE_WRAP16 = 2'b11
  } wb_bte_e;

  // beats in a burst less one
  function automatic logic [3:0] burst_beats(biu_type_e burst);
    case (burst)
      BIU_WRAP4, BIU_INCR4:   return 4'd3;
      BIU_WRAP8, BIU_INCR8:   return 4'd7;
      BIU_WRAP16, BIU_INCR16: return 4'd15;
      default:                return 4'd0;  // single, open incr
    endcase
  endfunction

  function automatic wb_bte_e type_to_bte(biu_type_e burst);
    case (burst)
      BIU_WRAP4:  return BTE_WRAP4;
      BIU_WRAP8:  return BTE_WRAP8;
      BIU_WRAP16: return BTE_WRAP16;
      default:    return BTE_LINEAR;
    endcase
  endfunction

  // byte lanes of one transfer, lane 0 at bit 0
  function automatic logic [7:0] byte_sel(biu_size_e size, logic [2:0] adr_lsb,
                                          int unsigned bus_bytes);
    logic [7:0]  lanes;
    int unsigned offs;
    offs = adr_lsb & (bus_bytes - 1);
    case (size)
      SIZE_BYTE:  lanes = 8'h01;
      SIZE_HWORD: lanes = 8'h03;
      SIZE_WORD:  lanes = 8'h0f;
      default:    lanes = 8'hff;
    endcase
    lanes = lanes << offs;
    if (bus_bytes < 8) lanes = lanes & 8'((1 << bus_bytes) - 1);  // trim to bus width
    return lanes;
  endfunction

  // next beat address; word stepped, wraps inside the aligned block
  function automatic logic [63:0] wb_next_adr(logic [63:0] adr, wb_bte_e bte,
                                              int unsigned bus_bytes);
    logic [63:0] step;
    logic [63:0] mask;
    step = (adr & ~64'(bus_bytes - 1)) + 64'(bus_bytes);
    case (bte)
      BTE_WRAP4:  mask = 64'(4 * bus_bytes - 1);
      BTE_WRAP8:  mask = 64'(8 * bus_bytes - 1);
      BTE_WRAP16: mask = 64'(16 * bus_bytes - 1);
      default:    mask = '1;  // linear
    endcase
    return (adr & ~mask) | (step & mask);
  endfunction

endpackage

/* biu2wb_bridge.sv */
// one request in flight; bursts step by bus words so sub-word sizes suit singles only; no retry
`timescale 1ns/10ps

module biu2wb_bridge #(
  parameter int XLEN = 32,
  parameter int PLEN = 32
) (
  input  logic                 HCLK,
  input  logic                 HRESETn,

  // core side
  input  logic                 biu_stb_i,
  output logic                 biu_stb_ack_o,   // request taken
  output logic                 biu_d_ack_o,     // write word consumed, present next
  input  logic [PLEN-1:0]      biu_adri_i,
  output logic [PLEN-1:0]      biu_adro_o,
  input  biu_pkg::biu_size_e   biu_size_i,
  input  biu_pkg::biu_type_e   biu_type_i,
  input  logic [2:0]           biu_prot_i,
  input  logic                 biu_lock_i,
  input  logic                 biu_we_i,
  input  logic [XLEN-1:0]      biu_d_i,
  output logic [XLEN-1:0]      biu_q_o,
  output logic                 biu_ack_o,       // beat done
  output logic                 biu_err_o,       // burst aborted

  // wishbone master
  output logic [PLEN-1:0]      wb_adr_o,
  output logic [XLEN-1:0]      wb_dat_o,
  output logic [XLEN/8-1:0]    wb_sel_o,
  output logic                 wb_we_o,
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output biu_pkg::wb_cti_e     wb_cti_o,
  output biu_pkg::wb_bte_e     wb_bte_o,
  output logic [2:0]           wb_tga_o,        // protection bits
  input  logic [XLEN-1:0]      wb_dat_i,
  input  logic                 wb_ack_i,
  input  logic                 wb_err_i
);

  localparam int BUS_BYTES = XLEN / 8;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BURST,
    ST_LOCK    // cyc held, waiting for next request
  } state_e;

  state_e                 state;
  logic [3:0]             beat_cnt;    // beats left after current one
  biu_pkg::biu_size_e     size_q;
  logic                   lock_q;
  logic                   take_req;
  logic                   last_beat;
  logic                   beat_done;
  logic [PLEN-1:0]        adr_nxt;
  logic [BUS_BYTES-1:0]   sel_start;
  logic [BUS_BYTES-1:0]   sel_nxt;

  ////////////////////
  // beat bookkeeping
  ////////////////////

  assign take_req  = biu_stb_i & (state != ST_BURST);    // idle or lock hold
  assign last_beat = (beat_cnt == 4'd0);
  assign beat_done = (state == ST_BURST) & wb_ack_i;

  // address of the following beat, wrap taken from bte
  assign adr_nxt = PLEN'(biu_pkg::wb_next_adr(64'(wb_adr_o), wb_bte_o, BUS_BYTES));

  assign sel_start = BUS_BYTES'(biu_pkg::byte_sel(biu_size_i, 3'(biu_adri_i), BUS_BYTES));
  assign sel_nxt   = BUS_BYTES'(biu_pkg::byte_sel(size_q, 3'(adr_nxt), BUS_BYTES));

  ////////////////////
  // cycle control FSM
  ////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state         <= ST_IDLE;
      beat_cnt      <= 4'd0;
      lock_q        <= 1'b0;
      wb_cyc_o      <= 1'b0;
      wb_stb_o      <= 1'b0;
      wb_we_o       <= 1'b0;
      wb_cti_o      <= biu_pkg::CTI_CLASSIC;
      wb_bte_o      <= biu_pkg::BTE_LINEAR;
      biu_stb_ack_o <= 1'b0;
      biu_d_ack_o   <= 1'b0;
      biu_err_o     <= 1'b0;
    end else begin
      biu_stb_ack_o <= 1'b0;  // pulses
      biu_d_ack_o   <= 1'b0;
      biu_err_o     <= 1'b0;

      case (state)
        ST_IDLE, ST_LOCK: begin
          if (take_req) begin
            state    <= ST_BURST;
            wb_cyc_o <= 1'b1;
            wb_stb_o <= 1'b1;   // rises on the edge that samples the strobe
            wb_we_o  <= biu_we_i;
            beat_cnt <= biu_pkg::burst_beats(biu_type_i);
            wb_bte_o <= biu_pkg::type_to_bte(biu_type_i);
            // a lone beat is classic, a burst opens incrementing
            wb_cti_o <= (biu_pkg::burst_beats(biu_type_i) == 4'd0) ?
                        biu_pkg::CTI_CLASSIC : biu_pkg::CTI_INCR;
            lock_q        <= biu_lock_i;
            biu_stb_ack_o <= 1'b1;
            biu_d_ack_o   <= biu_we_i;  // first word latched with the request
          end
        end

        ST_BURST: begin
          if (wb_err_i) begin
            // slave refused, abort rest of burst
            beat_cnt  <= 4'd0;
            wb_stb_o  <= 1'b0;
            wb_we_o   <= 1'b0;
            wb_cyc_o  <= lock_q;
            state     <= lock_q ? ST_LOCK : ST_IDLE;
            biu_err_o <= 1'b1;
          end else if (wb_ack_i) begin
            if (last_beat) begin
              wb_stb_o <= 1'b0;
              wb_we_o  <= 1'b0;
              wb_cyc_o <= lock_q;         // locked, keep the bus
              state    <= lock_q ? ST_LOCK : ST_IDLE;
            end else begin
              beat_cnt    <= beat_cnt - 4'd1;
              wb_cti_o    <= (beat_cnt == 4'd1) ? biu_pkg::CTI_EOB : biu_pkg::CTI_INCR;
              biu_d_ack_o <= wb_we_o;     // ask core for the next word
            end
          end
        end

        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////
  // address and data
  ////////////////////

  always_ff @(posedge HCLK) begin
    if (take_req) begin
      wb_adr_o <= biu_adri_i;
      wb_sel_o <= sel_start;
      wb_dat_o <= biu_d_i;
      wb_tga_o <= biu_prot_i;
      size_q   <= biu_size_i;
    end else if (beat_done && !last_beat) begin
      wb_adr_o <= adr_nxt;
      wb_sel_o <= sel_nxt;
      if (wb_we_o) wb_dat_o <= biu_d_i;  // word presented after last d_ack
    end
  end

  // read return straight from the slave
  assign biu_ack_o  = wb_ack_i & wb_stb_o;
  assign biu_q_o    = wb_dat_i;
  assign biu_adro_o = wb_adr_o;  // address of the beat being acked

endmodule

/* wb_burst_sram.sv */
// single master only; bursts assumed word stepped, acks and read data registered, no retry
`timescale 1ns/10ps

module wb_burst_sram #(
  parameter int XLEN      = 32,
  parameter int PLEN      = 32,
  parameter int MEM_WORDS = 256,
  parameter int PRIV_BASE = 192
) (
  input  logic                 HCLK,
  input  logic                 HRESETn,

  input  logic [PLEN-1:0]      wb_adr_i,
  input  logic [XLEN-1:0]      wb_dat_i,
  input  logic [XLEN/8-1:0]    wb_sel_i,
  input  logic                 wb_we_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  biu_pkg::wb_cti_e     wb_cti_i,
  input  biu_pkg::wb_bte_e     wb_bte_i,
  input  logic [2:0]           wb_tga_i,
  output logic [XLEN-1:0]      wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o
);

  localparam int BUS_BYTES = XLEN / 8;
  localparam int LSB       = $clog2(BUS_BYTES);
  localparam int IDX_W     = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [XLEN-1:0]       mem [MEM_WORDS];
  logic                  ack_q;
  logic                  err_q;
  logic [XLEN-1:0]       rd_q;
  logic                  req;
  logic                  burst_go;
  logic                  accept;
  logic [PLEN-1:0]       beat_adr;    // address of the beat acked next cycle
  logic [PLEN-LSB-1:0]   beat_idx;
  logic [PLEN-LSB-1:0]   cur_idx;     // beat on the bus now
  logic                  fault;

  ////////////////////
  // beat acceptance
  ////////////////////

  assign req = wb_cyc_i & wb_stb_i;

  // master keeps streaming, ack again next clock
  assign burst_go = ack_q & req &
                    ((wb_cti_i == biu_pkg::CTI_INCR) | (wb_cti_i == biu_pkg::CTI_CONST));

  // fresh beat only after a dead cycle, classic gets its gap this way
  assign accept = (req & ~ack_q & ~err_q) | burst_go;

  // master steps its address on this same edge, so predict it
  assign beat_adr = (burst_go && wb_cti_i == biu_pkg::CTI_INCR) ?
                    PLEN'(biu_pkg::wb_next_adr(64'(wb_adr_i), wb_bte_i, BUS_BYTES)) :
                    wb_adr_i;

  assign beat_idx = beat_adr[PLEN-1:LSB];
  assign cur_idx  = wb_adr_i[PLEN-1:LSB];

  // out of range, or privileged region without the flag
  assign fault = (beat_idx >= MEM_WORDS) |
                 ((beat_idx >= PRIV_BASE) & ~wb_tga_i[biu_pkg::PROT_PRIVILEGED]);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= accept & ~fault;
      err_q <= accept & fault;   // one clock, master drops stb on it
    end
  end

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge HCLK) begin
    if (accept && !fault) rd_q <= mem[beat_idx[IDX_W-1:0]];  // only in-range indices read

    // write lands on the acked beat, faulted beats never ack
    if (ack_q && req && wb_we_i) begin
      for (int b = 0; b < BUS_BYTES; b++) begin
        if (wb_sel_i[b]) mem[cur_idx[IDX_W-1:0]][b*8 +: 8] <= wb_dat_i[b*8 +: 8];
      end
    end
  end

  assign wb_dat_o = rd_q;
  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;

endmodule

/* biu_wb_subsys.sv */
// bridge plus memory on a private wishbone link; single core port, no arbitration
`timescale 1ns/10ps

module biu_wb_subsys #(
  parameter int XLEN      = 32,
  parameter int PLEN      = 32,
  parameter int MEM_WORDS = 256,
  parameter int PRIV_BASE = 192   // first word needing privilege
) (
  input  logic                 HCLK,
  input  logic                 HRESETn,

  // core data port
  input  logic                 biu_stb_i,
  output logic                 biu_stb_ack_o,
  output logic                 biu_d_ack_o,
  input  logic [PLEN-1:0]      biu_adri_i,
  output logic [PLEN-1:0]      biu_adro_o,
  input  biu_pkg::biu_size_e   biu_size_i,
  input  biu_pkg::biu_type_e   biu_type_i,
  input  logic [2:0]           biu_prot_i,
  input  logic                 biu_lock_i,
  input  logic                 biu_we_i,
  input  logic [XLEN-1:0]      biu_d_i,
  output logic [XLEN-1:0]      biu_q_o,
  output logic                 biu_ack_o,
  output logic                 biu_err_o
);

  // wishbone link
  logic [PLEN-1:0]      wb_adr;
  logic [XLEN-1:0]      wb_dat_m2s;   // write data
  logic [XLEN-1:0]      wb_dat_s2m;   // read data
  logic [XLEN/8-1:0]    wb_sel;
  logic                 wb_we;
  logic                 wb_cyc;
  logic                 wb_stb;
  biu_pkg::wb_cti_e     wb_cti;
  biu_pkg::wb_bte_e     wb_bte;
  logic [2:0]           wb_tga;
  logic                 wb_ack;
  logic                 wb_err;

  biu2wb_bridge #(
    .XLEN (XLEN),
    .PLEN (PLEN)
  ) biu2wb_bridge_inst (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .biu_stb_i     (biu_stb_i),
    .biu_stb_ack_o (biu_stb_ack_o),
    .biu_d_ack_o   (biu_d_ack_o),
    .biu_adri_i    (biu_adri_i),
    .biu_adro_o    (biu_adro_o),
    .biu_size_i    (biu_size_i),
    .biu_type_i    (biu_type_i),
    .biu_prot_i    (biu_prot_i),
    .biu_lock_i    (biu_lock_i),
    .biu_we_i      (biu_we_i),
    .biu_d_i       (biu_d_i),
    .biu_q_o       (biu_q_o),
    .biu_ack_o     (biu_ack_o),
    .biu_err_o     (biu_err_o),
    .wb_adr_o      (wb_adr),
    .wb_dat_o      (wb_dat_m2s),
    .wb_sel_o      (wb_sel),
    .wb_we_o       (wb_we),
    .wb_cyc_o      (wb_cyc),
    .wb_stb_o      (wb_stb),
    .wb_cti_o      (wb_cti),
    .wb_bte_o      (wb_bte),
    .wb_tga_o      (wb_tga),
    .wb_dat_i      (wb_dat_s2m),
    .wb_ack_i      (wb_ack),
    .wb_err_i      (wb_err)
  );

  wb_burst_sram #(
    .XLEN      (XLEN),
    .PLEN      (PLEN),
    .MEM_WORDS (MEM_WORDS),
    .PRIV_BASE (PRIV_BASE)
  ) wb_burst_sram_inst (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_m2s),
    .wb_sel_i (wb_sel),
    .wb_we_i  (wb_we),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_cti_i (wb_cti),
    .wb_bte_i (wb_bte),
    .wb_tga_i (wb_tga),
    .wb_dat_o (wb_dat_s2m),
    .wb_ack_o (wb_ack),
    .wb_err_o (wb_err)
  );

endmodule

/* tb_biu_wb.sv */
// reads biu_wb_trace.txt from the run directory; XLEN 32 only, latency checks assume a zero-wait memory
`timescale 1ns/10ps

module tb_biu_wb;

  localparam int MAX_TR = 64;

  logic                HCLK;
  logic                HRESETn;
  logic                biu_stb_i;
  logic                biu_stb_ack_o;
  logic                biu_d_ack_o;
  logic [31:0]         biu_adri_i;
  logic [31:0]         biu_adro_o;
  biu_pkg::biu_size_e  biu_size_i;
  biu_pkg::biu_type_e  biu_type_i;
  logic [2:0]          biu_prot_i;
  logic                biu_lock_i;
  logic                biu_we_i;
  logic [31:0]         biu_d_i;
  logic [31:0]         biu_q_o;
  logic                biu_ack_o;
  logic                biu_err_o;

  // trace with one entry per transfer
  int                  n_tr;
  int                  total_beats;
  logic                t_we   [MAX_TR];
  logic [2:0]          t_size [MAX_TR];
  logic [2:0]          t_type [MAX_TR];
  logic [2:0]          t_prot [MAX_TR];
  logic                t_lock [MAX_TR];
  logic [31:0]         t_adr  [MAX_TR];
  logic                t_err  [MAX_TR];
  int                  t_n    [MAX_TR];       // beats
  logic [31:0]         t_data [MAX_TR][16];
  logic [31:0]         tok    [24];           // fields of the line being parsed

  int                  err_cnt   = 0;
  int                  chk_cnt   = 0;
  int                  cyc_cnt   = 0;
  int                  cyc_limit = 0;         // 0 until the trace is loaded
  logic [31:0]         lfsr      = 32'd83744;

  biu_wb_subsys #(
    .XLEN      (32),
    .PLEN      (32),
    .MEM_WORDS (256),
    .PRIV_BASE (192)
  ) biu_wb_subsys_inst (.*);

  initial begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  // cycle count doubles as the watchdog
  always @(posedge HCLK) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_limit > 0 && cyc_cnt >= cyc_limit) begin
      $display("timeout: transfers still running after %0d cycles", cyc_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR at %0t: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int hex_val(byte c);
    if (c >= "0" && c <= "9") return c - "0";
    if (c >= "a" && c <= "f") return c - "a" + 10;
    if (c >= "A" && c <= "F") return c - "A" + 10;
    return -1;
  endfunction

  function automatic int split_hex(string line);
    int          n;
    int          d;
    int          i;
    logic [31:0] acc;
    bit          in_tok;
    n      = 0;
    acc    = '0;
    in_tok = 1'b0;
    for (i = 0; i <= line.len(); i++) begin
      d = (i < line.len()) ? hex_val(line[i]) : -1;  // string end closes a token
      if (d >= 0) begin
        acc    = {acc[27:0], 4'(d)};
        in_tok = 1'b1;
      end else if (in_tok) begin
        if (n < 24) tok[n] = acc;
        n++;
        acc    = '0;
        in_tok = 1'b0;
      end
    end
    return n;
  endfunction

  // word stepped; wrap types stay inside the block of beats*4 bytes
  function automatic logic [31:0] beat_adr(logic [31:0] start, logic [2:0] btype, int k);
    logic [31:0] lin;
    logic [31:0] blk;
    lin = start + 32'(4 * k);
    case (btype)
      biu_pkg::BIU_WRAP4:  blk = 32'd16;
      biu_pkg::BIU_WRAP8:  blk = 32'd32;
      biu_pkg::BIU_WRAP16: blk = 32'd64;
      default:             blk = 32'd0;   // linear
    endcase
    if (blk == 0) return lin;
    return (start & ~(blk - 1)) | (lin & (blk - 1));
  endfunction

  task automatic load_trace(output bit ok);
    int    fd;
    int    n;
    int    nd;
    int    k;
    int    line_no;
    string line;
    ok          = 1'b1;
    n_tr        = 0;
    total_beats = 0;
    line_no     = 0;
    fd = $fopen("biu_wb_trace.txt", "r");
    if (fd == 0) begin
      $display("trace file biu_wb_trace.txt could not be opened");
      ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        line_no++;
        n = (line.len() == 0 || line[0] == "#") ? 0 : split_hex(line);  // skip comments
        nd = n - 7;
        if (n > 0 && (nd < 1 || nd > 16 || n_tr >= MAX_TR ||
            nd != int'(biu_pkg::burst_beats(biu_pkg::biu_type_e'(tok[2][2:0]))) + 1)) begin
          $display("trace line %0d has a data word count that does not fit its burst type",
                   line_no);
          ok = 1'b0;
        end else if (n > 0) begin
          t_we[n_tr]   = tok[0][0];
          t_size[n_tr] = tok[1][2:0];
          t_type[n_tr] = tok[2][2:0];
          t_prot[n_tr] = tok[3][2:0];
          t_lock[n_tr] = tok[4][0];
          t_adr[n_tr]  = tok[5];
          t_n[n_tr]    = nd;
          t_err[n_tr]  = tok[n-1][0];
          for (k = 0; k < nd; k++) t_data[n_tr][k] = tok[6+k];
          total_beats += nd;
          n_tr++;
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////
  // one trace transfer
  ////////////////////

  task automatic run_transfer(input int t);
    int    beats;
    int    acks;
    int    errs;
    int    dacks;
    int    take_cyc;
    int    lat;
    int    gap;
    int    errs_before;
    bit    taken;
    string tag;
    beats       = t_n[t];
    acks        = 0;
    errs        = 0;
    dacks       = 0;
    taken       = 1'b0;
    errs_before = err_cnt;
    tag         = $sformatf("transfer %0d", t);
    @(negedge HCLK);
    biu_we_i   = t_we[t];
    biu_size_i = biu_pkg::biu_size_e'(t_size[t]);
    biu_type_i = biu_pkg::biu_type_e'(t_type[t]);
    biu_prot_i = t_prot[t];
    biu_lock_i = t_lock[t];
    biu_adri_i = t_adr[t];
    biu_d_i    = t_data[t][0];   // first word goes with the request
    biu_stb_i  = 1'b1;
    take_cyc   = cyc_cnt + 1;    // edge that samples the strobe
    while (acks < beats && errs == 0) begin
      @(negedge HCLK);
      if (biu_stb_ack_o && !taken) begin
        taken     = 1'b1;
        biu_stb_i = 1'b0;
        check_eq(cyc_cnt, take_cyc, {tag, " request ack cycle"});
      end
      if (biu_d_ack_o) begin
        dacks++;
        if (dacks < beats) biu_d_i = t_data[t][dacks];
      end
      if (biu_ack_o) begin
        lat = cyc_cnt + 1 - take_cyc;  // ack gets sampled on the coming edge
        check_eq(biu_adro_o, beat_adr(t_adr[t], t_type[t], acks), {tag, " beat address"});
        if (!t_we[t]) check_eq(biu_q_o, t_data[t][acks], {tag, " read data"});
        if (acks == 0) check_eq(lat, 2, {tag, " first ack latency"});
        if (acks == beats - 1) check_eq(lat, beats + 1, {tag, " clocks to last ack"});
        acks++;
      end
      if (biu_err_o) errs++;
    end
    check_eq(taken, 1'b1, {tag, " request taken"});
    check_eq(errs, t_err[t], {tag, " error pulses"});
    check_eq(acks, t_err[t] ? 0 : beats, {tag, " ack count"});
    check_eq(dacks, !t_we[t] ? 0 : (t_err[t] ? 1 : beats), {tag, " data ack count"});
    @(negedge HCLK);
    check_eq({biu_ack_o, biu_err_o, biu_d_ack_o, biu_stb_ack_o}, 4'b0000,
             {tag, " trailing pulses"});
    $display("%s %s %0d beat(s) at %h: %s", tag, t_we[t] ? "write" : "read", beats,
             t_adr[t], (err_cnt == errs_before) ? "ok" : "mismatch");
    if (!t_lock[t]) begin         // locked ones stay back to back
      gap = 0;
      repeat (2) begin
        gap  = (gap << 1) | int'(lfsr[0]);
        lfsr = lfsr_next(lfsr);
      end
      repeat (gap) @(negedge HCLK);
    end
  endtask

  initial begin : main
    bit ok;
    int t;
    HRESETn    = 1'b0;
    biu_stb_i  = 1'b0;
    biu_adri_i = '0;
    biu_size_i = biu_pkg::SIZE_WORD;
    biu_type_i = biu_pkg::BIU_SINGLE;
    biu_prot_i = 3'b000;
    biu_lock_i = 1'b0;
    biu_we_i   = 1'b0;
    biu_d_i    = '0;
    load_trace(ok);
    if (!ok) begin
      $display("trace could not be loaded, no transfers were run");
      $display("STATUS: FAIL");
    end else begin
      cyc_limit = total_beats * 4 + 100;
      repeat (8) @(negedge HCLK);
      check_eq({biu_stb_ack_o, biu_d_ack_o, biu_ack_o, biu_err_o}, 4'b0000, "reset outputs");
      HRESETn = 1'b1;
      for (t = 0; t < n_tr; t++) run_transfer(t);
      $display("%0d transfers, %0d checks, %0d errors", n_tr, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
    end
    $finish;
  end

endmodule

/* biu_wb_trace.txt */
# hex fields: we size type prot lock addr, one data word per beat (write data or expected read), error flag
# size 0 byte 1 half 2 word; type 0 single 2 wrap4 3 incr4 4 wrap8 5 incr8; prot bit 1 privileged
1 2 0 0 0 00000000 11223344 0
1 1 0 0 0 00000002 AABB0000 0
1 0 0 0 0 00000001 0000CC00 0
0 2 0 0 0 00000000 AABBCC44 0
1 2 0 0 0 00000004 55667788 0
1 0 0 0 0 00000007 99000000 0
1 1 0 0 0 00000004 0000DDEE 0
0 2 0 0 0 00000004 9966DDEE 0
1 2 5 0 0 00000040 3A5C96E1 7F0B24D8 C1E95A37 0D82F6B4 9B47E023 56A1CD8F E3F0127C 2874B9A6 0
0 2 5 0 0 00000040 3A5C96E1 7F0B24D8 C1E95A37 0D82F6B4 9B47E023 56A1CD8F E3F0127C 2874B9A6 0
0 2 4 0 0 00000050 9B47E023 56A1CD8F E3F0127C 2874B9A6 3A5C96E1 7F0B24D8 C1E95A37 0D82F6B4 0
1 2 3 0 0 00000100 4D9E1C72 B6033FA5 81C7D40E F25A6B19 0
0 2 2 0 0 00000108 81C7D40E F25A6B19 4D9E1C72 B6033FA5 0
1 2 2 0 0 000000C4 1357ACE0 2468BDF1 0F1E2D3C FEDCBA98 0
0 2 3 0 0 000000C0 FEDCBA98 1357ACE0 2468BDF1 0F1E2D3C 0
1 2 0 2 0 00000300 CAFEF00D 0
1 2 0 0 0 00000300 DEADBEEF 1
0 2 0 0 0 00000300 00000000 1
0 2 0 2 0 00000300 CAFEF00D 0
1 2 0 2 0 00000400 0BADC0DE 1
0 2 0 2 0 00000400 00000000 1
1 2 3 2 0 00000400 0BADC0DE 0BADC0DF 0BADC0E0 0BADC0E1 1
0 2 0 0 0 00000000 AABBCC44 0
1 2 0 0 1 00000080 600DCAFE 0
1 2 0 0 1 00000084 12345678 0
0 2 0 0 1 00000080 600DCAFE 0
0 2 3 0 1 00000040 3A5C96E1 7F0B24D8 C1E95A37 0D82F6B4 0
0 2 0 0 0 00000084 12345678 0
1 2 0 0 1 00000300 DEADBEEF 1
0 2 0 2 0 00000300 CAFEF00D 0

/* list.f */
biu_pkg.sv
biu2wb_bridge.sv
wb_burst_sram.sv
biu_wb_subsys.sv
tb_biu_wb.sv
